// ==== hdl/regmgr_pkg.sv ====
package regmgr_pkg;

  // bus address width
  localparam int addr_w = 32;

  // register and bus data width
  localparam int data_w = 32;

  // general registers per process
  localparam int reg_num_w = 4;

  // operation requested by the decoder, held for the whole operation
  typedef enum logic [2:0] {
    op_idle       = 3'd0,
    op_catch      = 3'd1,
    op_preexecute = 3'd2,
    op_read       = 3'd3,
    op_read_p     = 3'd4,
    op_write_prep = 3'd5,
    op_write      = 3'd6,
    op_write_p    = 3'd7
  } reg_op_t;

  // post-step applied on a direct write
  typedef enum logic [1:0] {
    step_none = 2'b00,
    step_inc  = 2'b01,
    step_dec  = 2'b10
  } step_t;

  // operation control from the decoder
  typedef struct packed {
    reg_op_t                reg_op;
    logic [reg_num_w-1:0]   reg_num;
    logic                   is_ptr;
    step_t                  step;
    // save permission from dispatch, carried with the operation
    logic                   save_allowed;
  } reg_ctrl_t;

  // request towards memory
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic              read_q;
    logic              write_q;
  } bus_req_t;

  // response from memory
  typedef struct packed {
    logic              busy;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic              read_dn;
    logic              write_dn;
  } bus_rsp_t;

endpackage

// ==== hdl/reg_fetch.sv ====
`timescale 1ns/1ps

module reg_fetch #(
  parameter int ADDR_W = regmgr_pkg::addr_w,
  parameter int DATA_W = regmgr_pkg::data_w
) (
  input  logic                  clk,
  input  logic                  rst,
  input  regmgr_pkg::reg_ctrl_t ctrl,
  input  logic [ADDR_W-1:0]     base_addr,
  input  logic                  disp_online,
  input  logic                  alu_results,
  input  logic [DATA_W-1:0]     catch_value,
  input  logic [DATA_W-1:0]     catch_ptr,
  input  regmgr_pkg::bus_rsp_t  bus_rsp,
  output regmgr_pkg::bus_req_t  fetch_req,
  output logic                  fetch_done,
  output logic [DATA_W-1:0]     register_value,
  output logic [DATA_W-1:0]     pointer_value
);

  // addresses of the two read kinds
  logic [ADDR_W-1:0] direct_addr;
  logic [ADDR_W-1:0] ptr_addr;
  logic [ADDR_W-1:0] read_addr;
  // address of the outstanding read
  logic [ADDR_W-1:0] pend_addr;

  logic is_read;
  logic is_catch;
  logic is_ack;
  logic armed;
  logic pending;
  logic caught;
  logic issue;
  logic hit;

  logic [DATA_W-1:0] register_q;
  logic [DATA_W-1:0] pointer_q;

  // register lives at base plus its number
  assign direct_addr = base_addr + ADDR_W'(ctrl.reg_num);
  // or at base plus the held pointer
  assign ptr_addr    = base_addr + ADDR_W'(pointer_q);

  assign is_read  = (ctrl.reg_op == regmgr_pkg::op_read) ||
                    (ctrl.reg_op == regmgr_pkg::op_read_p);
  assign is_catch = (ctrl.reg_op == regmgr_pkg::op_catch);
  // acknowledged every cycle the op is held
  assign is_ack   = is_catch || (ctrl.reg_op == regmgr_pkg::op_preexecute);

  assign read_addr = (ctrl.reg_op == regmgr_pkg::op_read_p) ? ptr_addr : direct_addr;

  // one request per dispatch, held off while memory is busy
  assign issue = is_read && disp_online && armed && !bus_rsp.busy;

  // completion only counts for our own address
  assign hit = is_read && pending && bus_rsp.busy && bus_rsp.read_dn &&
               (bus_rsp.addr == regmgr_pkg::addr_w'(pend_addr));

  always_comb begin
    fetch_req = '0;
    // address only valid in the request cycle
    if (issue) begin
      fetch_req.addr   = regmgr_pkg::addr_w'(read_addr);
      fetch_req.read_q = 1'b1;
    end
  end

  assign fetch_done = hit || is_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      armed      <= 1'b0;
      pending    <= 1'b0;
      caught     <= 1'b0;
      register_q <= '0;
      pointer_q  <= '0;
    end else begin
      // rearm between dispatches
      if (issue) begin
        armed <= 1'b0;
      end else if (!disp_online) begin
        armed <= 1'b1;
      end

      if (issue) begin
        pending <= 1'b1;
      end else if (hit || !is_read) begin
        pending <= 1'b0;
      end

      // drops as soon as the op moves on
      caught <= is_catch;

      // catch loads once per held op
      if (is_catch && !caught) begin
        if (alu_results) begin
          register_q <= catch_value;
        end else begin
          register_q <= catch_ptr;
          pointer_q  <= catch_ptr;
        end
      end

      if (hit) begin
        register_q <= DATA_W'(bus_rsp.data);
        // direct read also refreshes the pointer
        if (ctrl.reg_op == regmgr_pkg::op_read) begin
          pointer_q <= DATA_W'(bus_rsp.data);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      pend_addr <= read_addr;
    end
  end

  assign register_value = register_q;
  assign pointer_value  = pointer_q;

  // single-cycle read strobe
  a_read_q_pulse : assert property (@(posedge clk) disable iff (rst)
    fetch_req.read_q |=> !fetch_req.read_q);

endmodule

// ==== hdl/reg_store.sv ====
`timescale 1ns/1ps

module reg_store #(
  parameter int ADDR_W = regmgr_pkg::addr_w,
  parameter int DATA_W = regmgr_pkg::data_w
) (
  input  logic                  clk,
  input  logic                  rst,
  input  regmgr_pkg::reg_ctrl_t ctrl,
  input  logic [ADDR_W-1:0]     base_addr,
  input  logic                  disp_online,
  input  logic [DATA_W-1:0]     register_value,
  input  logic [DATA_W-1:0]     pointer_value,
  input  regmgr_pkg::bus_rsp_t  bus_rsp,
  output regmgr_pkg::bus_req_t  store_req,
  output logic                  store_done
);

  logic is_write;
  logic is_write_p;
  logic take_register;
  logic armed;
  logic pending;
  logic issue;
  logic hit;

  logic [DATA_W-1:0] src_value;
  logic [DATA_W-1:0] wr_data;
  logic [ADDR_W-1:0] wr_addr;
  // address of the outstanding write
  logic [ADDR_W-1:0] pend_addr;

  assign is_write_p = (ctrl.reg_op == regmgr_pkg::op_write_p);
  assign is_write   = (ctrl.reg_op == regmgr_pkg::op_write) || is_write_p;

  // register itself or the pointer copy
  assign take_register = (!ctrl.is_ptr && ctrl.reg_op == regmgr_pkg::op_write) ||
                         (ctrl.is_ptr && is_write_p);
  assign src_value = take_register ? register_value : pointer_value;

  // post step only on the direct write
  always_comb begin
    wr_data = src_value;
    if (!is_write_p) begin
      case (ctrl.step)
        regmgr_pkg::step_inc: wr_data = src_value + DATA_W'(1);
        regmgr_pkg::step_dec: wr_data = src_value - DATA_W'(1);
        default:              wr_data = src_value;
      endcase
    end
  end

  assign wr_addr = is_write_p ? base_addr + ADDR_W'(pointer_value)
                              : base_addr + ADDR_W'(ctrl.reg_num);

  assign issue = is_write && disp_online && armed && !bus_rsp.busy;

  assign hit = is_write && pending && bus_rsp.busy && bus_rsp.write_dn &&
               (bus_rsp.addr == regmgr_pkg::addr_w'(pend_addr));

  always_comb begin
    store_req = '0;
    if (issue) begin
      store_req.addr    = regmgr_pkg::addr_w'(wr_addr);
      store_req.data    = regmgr_pkg::data_w'(wr_data);
      store_req.write_q = 1'b1;
    end
  end

  // write prepare is a plain acknowledgement
  assign store_done = hit || (ctrl.reg_op == regmgr_pkg::op_write_prep);

  always_ff @(posedge clk) begin
    if (rst) begin
      armed   <= 1'b0;
      pending <= 1'b0;
    end else begin
      if (issue) begin
        armed <= 1'b0;
      end else if (!disp_online) begin
        armed <= 1'b1;
      end

      if (issue) begin
        pending <= 1'b1;
      end else if (hit || !is_write) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      pend_addr <= wr_addr;
    end
  end

  // single-cycle write strobe
  a_write_pulse : assert property (@(posedge clk) disable iff (rst)
    store_req.write_q |=> !store_req.write_q);

endmodule

// ==== hdl/reg_bus_port.sv ====
`timescale 1ns/1ps

module reg_bus_port #(
  parameter int ADDR_W = regmgr_pkg::addr_w,
  parameter int DATA_W = regmgr_pkg::data_w
) (
  input  logic                 clk,
  input  logic                 rst,
  input  regmgr_pkg::bus_req_t fetch_req,
  input  regmgr_pkg::bus_req_t store_req,
  input  logic                 fetch_done,
  input  logic                 store_done,
  output regmgr_pkg::bus_req_t bus_req,
  output logic                 next_state
);

  // idle units drive zero, so OR is a clean merge
  regmgr_pkg::bus_req_t merged_req;
  logic                 merged_done;

  logic fetch_active;
  logic store_active;

  assign merged_req  = regmgr_pkg::bus_req_t'(fetch_req | store_req);
  assign merged_done = fetch_done | store_done;

  assign fetch_active = fetch_req.read_q | fetch_req.write_q;
  assign store_active = store_req.read_q | store_req.write_q;

  // single output register stage for the bus and the handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_req    <= '0;
      next_state <= 1'b0;
    end else begin
      bus_req    <= merged_req;
      next_state <= merged_done;
    end
  end

  // only one op is current, so units never collide
  a_one_requester : assert property (@(posedge clk) disable iff (rst)
    !(fetch_active && store_active));

endmodule

// ==== hdl/reg_manager.sv ====
`timescale 1ns/1ps

module reg_manager #(
  parameter int ADDR_W = regmgr_pkg::addr_w,
  parameter int DATA_W = regmgr_pkg::data_w
) (
  input  logic                  clk,
  input  logic                  rst,
  input  regmgr_pkg::reg_ctrl_t ctrl,
  input  logic [ADDR_W-1:0]     base_addr,
  input  logic                  disp_online,
  input  logic                  alu_results,
  input  logic [DATA_W-1:0]     catch_value,
  input  logic [DATA_W-1:0]     catch_ptr,
  input  regmgr_pkg::bus_rsp_t  bus_rsp,
  output regmgr_pkg::bus_req_t  bus_req,
  output logic [DATA_W-1:0]     register_value,
  output logic [DATA_W-1:0]     ptr_value,
  output logic                  next_state
);

  regmgr_pkg::bus_req_t fetch_req;
  regmgr_pkg::bus_req_t store_req;
  logic                 fetch_done;
  logic                 store_done;

  // catch, reads, holds register and pointer
  reg_fetch #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_fetch (
    .clk            (clk),
    .rst            (rst),
    .ctrl           (ctrl),
    .base_addr      (base_addr),
    .disp_online    (disp_online),
    .alu_results    (alu_results),
    .catch_value    (catch_value),
    .catch_ptr      (catch_ptr),
    .bus_rsp        (bus_rsp),
    .fetch_req      (fetch_req),
    .fetch_done     (fetch_done),
    .register_value (register_value),
    .pointer_value  (ptr_value)
  );

  // writes from the held values
  reg_store #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_store (
    .clk            (clk),
    .rst            (rst),
    .ctrl           (ctrl),
    .base_addr      (base_addr),
    .disp_online    (disp_online),
    .register_value (register_value),
    .pointer_value  (ptr_value),
    .bus_rsp        (bus_rsp),
    .store_req      (store_req),
    .store_done     (store_done)
  );

  reg_bus_port #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_bus_port (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .store_req  (store_req),
    .fetch_done (fetch_done),
    .store_done (store_done),
    .bus_req    (bus_req),
    .next_state (next_state)
  );

endmodule

// ==== tests/tb_reg_manager.sv ====
`timescale 1ns/1ps

module tb_reg_manager;

  localparam int addr_w = regmgr_pkg::addr_w;
  localparam int data_w = regmgr_pkg::data_w;
  localparam int num_tests = 6;
  // run budget of 40 cycles per test
  localparam int cycle_limit = num_tests * 40;

  // predicted bus access and held values after one op
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic [data_w-1:0] reg_v;
    logic [data_w-1:0] ptr_v;
  } expect_t;

  logic clk = 1'b0;
  logic rst;
  regmgr_pkg::reg_ctrl_t ctrl;
  logic [addr_w-1:0] base_addr;
  logic disp_online;
  logic alu_results;
  logic [data_w-1:0] catch_value;
  logic [data_w-1:0] catch_ptr;
  regmgr_pkg::bus_rsp_t bus_rsp = '0;
  regmgr_pkg::bus_req_t bus_req;
  logic [data_w-1:0] register_value;
  logic [data_w-1:0] ptr_value;
  logic next_state;

  // memory responder state
  logic [data_w-1:0] mem [256];
  logic [data_w-1:0] shadow [256];
  logic [31:0] lfsr = 32'hd5e5;
  logic [1:0] mem_wait;
  logic mem_active;
  regmgr_pkg::bus_req_t mem_req;

  int cycle_count = 0;
  int req_count = 0;
  int errors = 0;
  int checks = 0;
  int tests_failed = 0;
  int errors_at_start = 0;
  int idx;
  // 0 none, 1 read, 2 write
  int exp_kind = 0;
  logic [addr_w-1:0] exp_addr;
  logic [data_w-1:0] exp_data;
  logic [data_w-1:0] exp_reg;
  logic [data_w-1:0] exp_ptr;

  reg_manager #(.ADDR_W(addr_w), .DATA_W(data_w)) dut (.*);

  always #20 clk = ~clk;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // every address bit shows up in the word
  function automatic logic [data_w-1:0] fill_word(input int a);
    return {8'hc3, a[7:0], ~a[7:0], a[7:0] ^ 8'h5a};
  endfunction

  function automatic regmgr_pkg::reg_ctrl_t make_ctrl(input regmgr_pkg::reg_op_t op,
      input logic [regmgr_pkg::reg_num_w-1:0] num, input logic is_ptr,
      input regmgr_pkg::step_t step);
    regmgr_pkg::reg_ctrl_t c;
    c = '0;
    c.reg_op = op;
    c.reg_num = num;
    c.is_ptr = is_ptr;
    c.step = step;
    return c;
  endfunction

  // reference model of one op against the held values
  function automatic expect_t predict_op(input regmgr_pkg::reg_ctrl_t c);
    expect_t e;
    logic [data_w-1:0] src;
    e = '0;
    e.reg_v = exp_reg;
    e.ptr_v = exp_ptr;
    src = exp_ptr;
    // register is the source only when is_ptr matches the write kind
    if ((c.reg_op == regmgr_pkg::op_write && !c.is_ptr) ||
        (c.reg_op == regmgr_pkg::op_write_p && c.is_ptr))
      src = exp_reg;
    case (c.reg_op)
      regmgr_pkg::op_catch: begin
        e.reg_v = alu_results ? catch_value : catch_ptr;
        if (!alu_results)
          e.ptr_v = catch_ptr;
      end
      regmgr_pkg::op_read: begin
        e.addr = base_addr + addr_w'(c.reg_num);
        e.reg_v = shadow[e.addr[7:0]];
        e.ptr_v = e.reg_v;
      end
      regmgr_pkg::op_read_p: begin
        e.addr = base_addr + addr_w'(exp_ptr);
        e.reg_v = shadow[e.addr[7:0]];
      end
      regmgr_pkg::op_write: begin
        e.addr = base_addr + addr_w'(c.reg_num);
        e.data = src;
        if (c.step == regmgr_pkg::step_inc)
          e.data = src + 1;
        else if (c.step == regmgr_pkg::step_dec)
          e.data = src - 1;
      end
      regmgr_pkg::op_write_p: begin
        e.addr = base_addr + addr_w'(exp_ptr);
        e.data = src;
      end
      default: begin
      end
    endcase
    return e;
  endfunction

  task automatic check_data(input logic [data_w-1:0] act, input logic [data_w-1:0] exp,
      input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input logic [addr_w-1:0] act, input logic [addr_w-1:0] exp,
      input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_pulse(input logic act, input logic exp, input string name);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic release_op();
    ctrl <= make_ctrl(regmgr_pkg::op_idle, '0, 1'b0, regmgr_pkg::step_none);
    disp_online <= 1'b0;
    exp_kind <= 0;
  endtask

  // read or write op held until next_state
  task automatic run_bus_op(input regmgr_pkg::reg_ctrl_t c);
    expect_t e;
    int count_before;
    @(posedge clk);
    e = predict_op(c);
    count_before = req_count;
    exp_kind <= (c.reg_op == regmgr_pkg::op_read || c.reg_op == regmgr_pkg::op_read_p) ? 1 : 2;
    exp_addr <= e.addr;
    exp_data <= e.data;
    ctrl <= c;
    disp_online <= 1'b1;
    do @(posedge clk); while (next_state !== 1'b1);
    check_data(register_value, e.reg_v, "register_value");
    check_data(ptr_value, e.ptr_v, "ptr_value");
    if (req_count != count_before + 1)
      report_failure("operation did not issue exactly one bus request");
    if (exp_kind == 2) begin
      check_data(mem[e.addr[7:0]], e.data, "memory word");
      shadow[e.addr[7:0]] = e.data;
    end
    exp_reg = e.reg_v;
    exp_ptr = e.ptr_v;
    release_op();
    @(posedge clk);
    // completion strobe one cycle wide
    check_pulse(next_state, 1'b0, "next_state");
    repeat (2) @(posedge clk);
  endtask

  // acknowledge ops give a repeated ack and no bus traffic
  task automatic run_ack_op(input regmgr_pkg::reg_ctrl_t c);
    expect_t e;
    @(posedge clk);
    e = predict_op(c);
    ctrl <= c;
    disp_online <= 1'b1;
    @(posedge clk);
    check_pulse(next_state, 1'b0, "next_state");
    @(posedge clk);
    check_pulse(next_state, 1'b1, "next_state");
    // catch sources move while op still held
    catch_value <= ~catch_value;
    catch_ptr <= catch_ptr + 32'h10;
    repeat (3) begin
      @(posedge clk);
      check_pulse(next_state, 1'b1, "next_state");
    end
    check_data(register_value, e.reg_v, "register_value");
    check_data(ptr_value, e.ptr_v, "ptr_value");
    exp_reg = e.reg_v;
    exp_ptr = e.ptr_v;
    release_op();
    repeat (3) @(posedge clk);
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", num, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // memory holds busy through a random 0..3 cycle wait then returns done with the address
  always @(posedge clk) begin
    if (rst) begin
      bus_rsp <= '0;
      mem_active <= 1'b0;
    end else if (!mem_active) begin
      bus_rsp <= '0;
      if (bus_req.read_q || bus_req.write_q) begin
        mem_req <= bus_req;
        mem_active <= 1'b1;
        bus_rsp.busy <= 1'b1;
        lfsr = lfsr_next(lfsr);
        mem_wait[0] <= lfsr[0];
        lfsr = lfsr_next(lfsr);
        mem_wait[1] <= lfsr[0];
      end
    end else if (mem_wait != 2'd0) begin
      mem_wait <= mem_wait - 2'd1;
    end else begin
      bus_rsp.addr <= mem_req.addr;
      bus_rsp.read_dn <= mem_req.read_q;
      bus_rsp.write_dn <= mem_req.write_q;
      if (mem_req.read_q)
        bus_rsp.data <= mem[mem_req.addr[7:0]];
      if (mem_req.write_q)
        mem[mem_req.addr[7:0]] <= mem_req.data;
      mem_active <= 1'b0;
    end
  end

  // bus monitor against the predicted request
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (!rst && (bus_req.read_q || bus_req.write_q)) begin
      req_count <= req_count + 1;
      if (exp_kind == 0) begin
        report_failure("bus request while no read or write was current");
      end else begin
        check_pulse(bus_req.read_q, exp_kind == 1, "bus_req.read_q");
        check_pulse(bus_req.write_q, exp_kind == 2, "bus_req.write_q");
        check_addr(bus_req.addr, exp_addr, "bus_req.addr");
        check_data(bus_req.data, exp_data, "bus_req.data");
      end
    end else if (!rst) begin
      // idle bus carries zeros
      check_addr(bus_req.addr, '0, "bus_req.addr");
      check_data(bus_req.data, '0, "bus_req.data");
    end
  end

  initial begin
    wait (cycle_count >= cycle_limit);
    $display("timeout: run stopped after %0d cycles", cycle_limit);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    rst = 1'b1;
    ctrl = make_ctrl(regmgr_pkg::op_idle, '0, 1'b0, regmgr_pkg::step_none);
    base_addr = 32'h0000_0040;
    disp_online = 1'b0;
    alu_results = 1'b0;
    catch_value = '0;
    catch_ptr = '0;
    exp_reg = '0;
    exp_ptr = '0;
    for (idx = 0; idx < 256; idx++) begin
      mem[idx] = fill_word(idx);
      shadow[idx] = fill_word(idx);
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    @(posedge clk);
    check_pulse(bus_req.read_q, 1'b0, "bus_req.read_q");
    check_pulse(bus_req.write_q, 1'b0, "bus_req.write_q");
    check_pulse(next_state, 1'b0, "next_state");
    check_data(register_value, '0, "register_value");
    check_data(ptr_value, '0, "ptr_value");
    // read held with dispatch offline stays quiet
    ctrl <= make_ctrl(regmgr_pkg::op_read, 4'd1, 1'b0, regmgr_pkg::step_none);
    repeat (6) @(posedge clk);
    if (req_count != 0)
      report_failure("read issued while disp_online was low");
    release_op();
    repeat (2) @(posedge clk);
    end_test(1, "reset and offline dispatch");

    run_bus_op(make_ctrl(regmgr_pkg::op_read, 4'd5, 1'b0, regmgr_pkg::step_none));
    end_test(2, "direct read");

    // pointer comes from catch_ptr
    alu_results <= 1'b0;
    catch_ptr <= 32'h0000_0023;
    run_ack_op(make_ctrl(regmgr_pkg::op_catch, 4'd0, 1'b0, regmgr_pkg::step_none));
    run_bus_op(make_ctrl(regmgr_pkg::op_read_p, 4'd0, 1'b1, regmgr_pkg::step_none));
    end_test(3, "pointer read");

    run_bus_op(make_ctrl(regmgr_pkg::op_write, 4'd2, 1'b0, regmgr_pkg::step_inc));
    run_bus_op(make_ctrl(regmgr_pkg::op_write, 4'd3, 1'b0, regmgr_pkg::step_dec));
    run_bus_op(make_ctrl(regmgr_pkg::op_write, 4'd4, 1'b0, regmgr_pkg::step_none));
    end_test(4, "direct write with post step");

    alu_results <= 1'b1;
    catch_value <= 32'hc0ff_ee11;
    run_ack_op(make_ctrl(regmgr_pkg::op_catch, 4'd0, 1'b0, regmgr_pkg::step_none));
    // step is ignored on a pointer write
    run_bus_op(make_ctrl(regmgr_pkg::op_write_p, 4'd0, 1'b1, regmgr_pkg::step_inc));
    end_test(5, "pointer write");

    catch_value <= 32'h1234_5678;
    run_ack_op(make_ctrl(regmgr_pkg::op_catch, 4'd0, 1'b0, regmgr_pkg::step_none));
    run_ack_op(make_ctrl(regmgr_pkg::op_preexecute, 4'd0, 1'b0, regmgr_pkg::step_none));
    run_ack_op(make_ctrl(regmgr_pkg::op_write_prep, 4'd0, 1'b0, regmgr_pkg::step_none));
    end_test(6, "acknowledge ops and single catch");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             num_tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/regmgr_pkg.sv
hdl/reg_fetch.sv
hdl/reg_store.sv
hdl/reg_bus_port.sv
hdl/reg_manager.sv
tests/tb_reg_manager.sv

// ==== Bender.yml ====
package:
  name: reg_manager

sources:
  - files:
      - hdl/regmgr_pkg.sv
      - hdl/reg_fetch.sv
      - hdl/reg_store.sv
      - hdl/reg_bus_port.sv
      - hdl/reg_manager.sv
  - target: test
    files:
      - tests/tb_reg_manager.sv
